// ==== mio.f ====
src/mio_pkg.sv
src/mio_regs.sv
src/mio_tx.sv
src/mio_rx.sv
src/mio.sv
src/mio_loopback.sv
verification/mio_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the loopback testbench with Verilator and run it
verilator --binary --timing --assert -Wno-fatal --top-module mio_tb -f mio.f -o mio_sim &&
./obj_dir/mio_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== src/mio.sv ====
`timescale 1ns/1ps

module mio #(
	parameter int                NMIO    = 8,
	parameter mio_pkg::mio_cfg_t DEF_CFG = '{enable: 1'b1, clkdiv: 4'd1}
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   access_in,      // Link packet strobe
	input  mio_pkg::emesh_packet_t packet_in,
	input  logic                   wait_in,
	input  logic                   reg_access_in,  // Register packet strobe
	input  mio_pkg::emesh_packet_t reg_packet_in,
	input  logic                   reg_wait_in,
	input  logic                   rx_clk,
	input  logic                   rx_access,
	input  logic [NMIO-1:0]        rx_packet,
	input  logic                   tx_wait,
	output logic                   wait_out,
	output logic                   access_out,
	output mio_pkg::emesh_packet_t packet_out,
	output logic                   reg_access_out,
	output mio_pkg::emesh_packet_t reg_packet_out,
	output logic                   reg_wait_out,
	output logic                   tx_clk,
	output logic                   tx_access,
	output logic [NMIO-1:0]        tx_packet,
	output logic                   rx_wait
);

	mio_pkg::mio_cfg_t cfg;  // From register file
	logic              sent; // Transmitter done pulse

	//############################
	//# Transmit side
	//############################
	mio_tx #(.NMIO(NMIO)) tx0 (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.access_in (access_in),
		.packet_in (packet_in),
		.tx_wait   (tx_wait),
		.wait_out  (wait_out),
		.tx_clk    (tx_clk),
		.tx_access (tx_access),
		.tx_packet (tx_packet),
		.sent      (sent)
	);

	//############################
	//# Receive side
	//############################
	mio_rx #(.NMIO(NMIO)) rx0 (
		.clk        (clk),
		.rst        (rst),
		.rx_clk     (rx_clk),
		.rx_access  (rx_access),
		.rx_packet  (rx_packet),
		.wait_in    (wait_in),
		.rx_wait    (rx_wait),
		.access_out (access_out),
		.packet_out (packet_out)
	);

	// Config and status
	mio_regs #(.DEF_CFG(DEF_CFG)) regs0 (
		.clk            (clk),
		.rst            (rst),
		.reg_access_in  (reg_access_in),
		.reg_packet_in  (reg_packet_in),
		.reg_wait_in    (reg_wait_in),
		.sent           (sent),
		.reg_wait_out   (reg_wait_out),
		.reg_access_out (reg_access_out),
		.reg_packet_out (reg_packet_out),
		.cfg            (cfg)
	);

endmodule

// ==== src/mio_loopback.sv ====
`timescale 1ns/1ps

module mio_loopback #(
	parameter int                NMIO    = 8,                                // Link width
	parameter mio_pkg::mio_cfg_t DEF_CFG = '{enable: 1'b1, clkdiv: 4'd1} // Enabled, div 1
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   access_in,
	input  mio_pkg::emesh_packet_t packet_in,
	input  logic                   wait_in,        // Link output back-pressure
	input  logic                   reg_wait_in,    // Register output back-pressure
	output logic                   wait_out,       // Link path busy
	output logic                   reg_wait_out,   // Register path busy
	output logic                   access_out,
	output logic                   reg_access_out,
	output mio_pkg::emesh_packet_t packet_out,
	output mio_pkg::emesh_packet_t reg_packet_out,
	output logic                   tx_clk          // Forwarded clock, observed
);

	logic            reg_space;     // Upper address bits all zero
	logic            mio_access_in;
	logic            reg_access_in;
	logic            tx_access;
	logic [NMIO-1:0] tx_packet;
	logic            rx_wait;

	//############################
	//# Address decode
	//############################
	assign reg_space     = ~|packet_in.dstaddr[31 -: mio_pkg::REG_SPACE_BITS];
	assign mio_access_in = access_in & ~reg_space; // To link
	assign reg_access_in = access_in & reg_space;  // To register file

	//############################
	//# Link core, pins looped back
	//############################
	mio #(.NMIO(NMIO), .DEF_CFG(DEF_CFG)) mio0 (
		.clk            (clk),
		.rst            (rst),
		.access_in      (mio_access_in),
		.packet_in      (packet_in),
		.wait_in        (wait_in),
		.reg_access_in  (reg_access_in),
		.reg_packet_in  (packet_in),      // Shared request bus
		.reg_wait_in    (reg_wait_in),
		.rx_clk         (tx_clk),         // Loopback
		.rx_access      (tx_access),      // Loopback
		.rx_packet      (tx_packet),      // Loopback
		.tx_wait        (rx_wait),        // Receiver stalls transmitter
		.wait_out       (wait_out),
		.access_out     (access_out),
		.packet_out     (packet_out),
		.reg_access_out (reg_access_out),
		.reg_packet_out (reg_packet_out),
		.reg_wait_out   (reg_wait_out),
		.tx_clk         (tx_clk),
		.tx_access      (tx_access),
		.tx_packet      (tx_packet),
		.rx_wait        (rx_wait)
	);

endmodule

// ==== src/mio_pkg.sv ====
package mio_pkg;

	//############################
	//# Widths
	//############################
	localparam int PW             = 104; // Full packet width
	localparam int DIV_BITS       = 4;   // Clock divider field
	localparam int REG_SPACE_BITS = 12;  // Upper dstaddr bits, zero selects registers

	//############################
	//# Packet and config
	//############################
	typedef struct packed {
		logic [31:0] srcaddr; // Bits 103..72
		logic [31:0] data;    // Bits 71..40
		logic [31:0] dstaddr; // Bits 39..8
		logic [7:0]  ctrl;    // Bit 0 is write
	} emesh_packet_t;

	typedef struct packed {
		logic                enable; // Link accepts packets
		logic [DIV_BITS-1:0] clkdiv; // Phase length minus one
	} mio_cfg_t;

	//############################
	//# Enums
	//############################
	// Register index from dstaddr[3:2]
	typedef enum logic [1:0] {
		REG_CONFIG  = 2'd0, // Enable and divider
		REG_STATUS  = 2'd1, // Sent packet count
		REG_SCRATCH = 2'd2  // Free word
	} mio_reg_e;

	typedef enum logic [1:0] {
		TX_IDLE = 2'd0, // No packet held
		TX_LOW  = 2'd1, // Beat setup, tx_clk low
		TX_HIGH = 2'd2  // Beat taken, tx_clk high
	} mio_tx_state_e;

endpackage

// ==== src/mio_regs.sv ====
`timescale 1ns/1ps

module mio_regs #(
	parameter mio_pkg::mio_cfg_t DEF_CFG = '{enable: 1'b1, clkdiv: 4'd1}
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   reg_access_in,
	input  mio_pkg::emesh_packet_t reg_packet_in,
	input  logic                   reg_wait_in,    // Response back-pressure
	input  logic                   sent,           // Link packet done
	output logic                   reg_wait_out,
	output logic                   reg_access_out,
	output mio_pkg::emesh_packet_t reg_packet_out,
	output mio_pkg::mio_cfg_t      cfg             // Live config to link
);

	mio_pkg::mio_cfg_t      cfg_q;      // Config register
	logic [31:0]            status_q;   // Sent packet counter
	logic [31:0]            scratch_q;  // Scratch word
	logic [31:0]            rdata;      // Selected read value
	logic                   take;       // Request accepted
	logic                   is_write;
	mio_pkg::mio_reg_e      reg_idx;
	logic                   resp_valid; // Read response pending
	mio_pkg::emesh_packet_t resp_q;

	//############################
	//# Decode
	//############################
	assign take     = reg_access_in & ~reg_wait_out;
	assign is_write = reg_packet_in.ctrl[0];
	assign reg_idx  = mio_pkg::mio_reg_e'(reg_packet_in.dstaddr[3:2]); // Word index

	always_comb begin
		case (reg_idx)
			mio_pkg::REG_CONFIG:  rdata = {24'd0, cfg_q.clkdiv, 3'd0, cfg_q.enable};
			mio_pkg::REG_STATUS:  rdata = status_q;
			mio_pkg::REG_SCRATCH: rdata = scratch_q;
			default:              rdata = 32'd0; // Unmapped slot reads zero
		endcase
	end

	//############################
	//# Register updates
	//############################
	always_ff @(posedge clk) begin
		if (rst) begin
			cfg_q      <= DEF_CFG;
			status_q   <= 32'd0;
			scratch_q  <= 32'd0;
			resp_valid <= 1'b0;
		end else begin
			if (sent) begin
				status_q <= status_q + 32'd1; // Count finished link packets
			end
			if (take && is_write) begin
				case (reg_idx)
					mio_pkg::REG_CONFIG: begin
						cfg_q.enable <= reg_packet_in.data[0];
						cfg_q.clkdiv <= reg_packet_in.data[7:4];
					end
					mio_pkg::REG_SCRATCH: scratch_q <= reg_packet_in.data;
					default: ; // Status is read only
				endcase
			end
			if (take && !is_write) begin
				resp_valid <= 1'b1; // Response next cycle
			end else if (!reg_wait_in) begin
				resp_valid <= 1'b0; // Response taken
			end
		end
	end

	// Read response, addresses swapped
	always_ff @(posedge clk) begin
		if (take && !is_write) begin
			resp_q.ctrl    <= reg_packet_in.ctrl | 8'h01; // Marks a write back
			resp_q.dstaddr <= reg_packet_in.srcaddr;
			resp_q.srcaddr <= reg_packet_in.dstaddr;
			resp_q.data    <= rdata;
		end
	end

	assign reg_wait_out   = resp_valid; // Hold requests while pending
	assign reg_access_out = resp_valid;
	assign reg_packet_out = resp_q;
	assign cfg            = cfg_q;

endmodule

// ==== src/mio_rx.sv ====
`timescale 1ns/1ps

module mio_rx #(
	parameter int NMIO = 8 // Link width, must divide PW
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rx_clk,     // Forwarded clock level
	input  logic                   rx_access,
	input  logic [NMIO-1:0]        rx_packet,
	input  logic                   wait_in,    // Downstream back-pressure
	output logic                   rx_wait,    // Output register full
	output logic                   access_out,
	output mio_pkg::emesh_packet_t packet_out
);

	localparam int BEATS = mio_pkg::PW / NMIO;
	localparam int BW    = (BEATS > 1) ? $clog2(BEATS) : 1;

	logic                   rx_clk_q;  // Previous rx_clk sample
	logic                   rx_rise;
	logic                   take_beat;
	logic                   last_beat;
	logic [BW-1:0]          beat_cnt;  // Beats collected
	logic [mio_pkg::PW-1:0] shreg;     // Partial packet, fills from top
	logic [mio_pkg::PW-1:0] assembled; // Shreg with current beat
	logic                   out_valid;
	mio_pkg::emesh_packet_t out_q;

	//############################
	//# Edge detect and assembly
	//############################
	assign rx_rise   = rx_clk & ~rx_clk_q;
	assign take_beat = rx_rise & rx_access;
	assign last_beat = (beat_cnt == BW'(BEATS - 1));
	assign assembled = {rx_packet, shreg[mio_pkg::PW-1:NMIO]}; // New beat on top

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_clk_q  <= 1'b0;
			beat_cnt  <= '0;
			out_valid <= 1'b0;
		end else begin
			rx_clk_q <= rx_clk;
			if (take_beat) begin
				beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
			end
			if (take_beat && last_beat) begin
				out_valid <= 1'b1; // Packet complete
			end else if (!wait_in) begin
				out_valid <= 1'b0; // Taken downstream
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_beat) begin
			shreg <= assembled;
		end
		if (take_beat && last_beat) begin
			out_q <= mio_pkg::emesh_packet_t'(assembled); // First beat lands in low bits
		end
	end

	//############################
	//# Outputs
	//############################
	assign rx_wait    = out_valid; // Stall transmitter until drained
	assign access_out = out_valid;
	assign packet_out = out_q;

endmodule

// ==== src/mio_tx.sv ====
`timescale 1ns/1ps

module mio_tx #(
	parameter int NMIO = 8 // Link width, must divide PW
) (
	input  logic                   clk,
	input  logic                   rst,
	input  mio_pkg::mio_cfg_t      cfg,       // Live config
	input  logic                   access_in,
	input  mio_pkg::emesh_packet_t packet_in,
	input  logic                   tx_wait,   // Receiver full
	output logic                   wait_out,
	output logic                   tx_clk,    // Forwarded clock level
	output logic                   tx_access,
	output logic [NMIO-1:0]        tx_packet,
	output logic                   sent       // Pulse after last beat
);

	localparam int BEATS = mio_pkg::PW / NMIO;             // Beats per packet
	localparam int BW    = (BEATS > 1) ? $clog2(BEATS) : 1; // Beat counter width

	mio_pkg::mio_tx_state_e        state;
	logic [mio_pkg::PW-1:0]        shreg;      // Outgoing packet, low beat first
	logic [BW-1:0]                 beat_cnt;   // Beats already taken
	logic [mio_pkg::DIV_BITS-1:0]  phase_cnt;  // Cycles spent in phase
	logic [mio_pkg::DIV_BITS-1:0]  phase_len;  // Divider latched per phase
	logic                          phase_done;
	logic                          last_beat;
	logic                          take;       // Packet accepted

	assign wait_out   = (state != mio_pkg::TX_IDLE) | ~cfg.enable;
	assign take       = access_in & ~wait_out;
	assign phase_done = (phase_cnt == phase_len);
	assign last_beat  = (beat_cnt == BW'(BEATS - 1));

	//############################
	//# Phase FSM
	//############################
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= mio_pkg::TX_IDLE;
			beat_cnt  <= '0;
			phase_cnt <= '0;
			phase_len <= '0;
			sent      <= 1'b0;
		end else begin
			sent <= 1'b0;
			case (state)
				mio_pkg::TX_IDLE: begin
					if (take) begin
						state     <= mio_pkg::TX_LOW;
						beat_cnt  <= '0;
						phase_cnt <= '0;
						phase_len <= cfg.clkdiv; // First low phase
					end
				end
				mio_pkg::TX_LOW: begin
					if (!phase_done) begin
						phase_cnt <= phase_cnt + 1'b1;
					end else if (!tx_wait) begin
						state     <= mio_pkg::TX_HIGH; // Rising edge takes beat
						phase_cnt <= '0;
						phase_len <= cfg.clkdiv;
					end
				end
				mio_pkg::TX_HIGH: begin
					if (!phase_done) begin
						phase_cnt <= phase_cnt + 1'b1;
					end else if (last_beat) begin
						state <= mio_pkg::TX_IDLE;
						sent  <= 1'b1; // Whole packet out
					end else begin
						state     <= mio_pkg::TX_LOW;
						beat_cnt  <= beat_cnt + 1'b1;
						phase_cnt <= '0;
						phase_len <= cfg.clkdiv; // New divider lands here
					end
				end
				default: state <= mio_pkg::TX_IDLE;
			endcase
		end
	end

	//############################
	//# Beat shifter
	//############################
	always_ff @(posedge clk) begin
		if (take) begin
			shreg <= packet_in;
		end else if (state == mio_pkg::TX_HIGH && phase_done) begin
			shreg <= shreg >> NMIO; // Next beat into low bits
		end
	end

	assign tx_clk    = (state == mio_pkg::TX_HIGH);
	assign tx_access = (state != mio_pkg::TX_IDLE);
	assign tx_packet = shreg[NMIO-1:0];

endmodule

// ==== verification/mio_tb.sv ====
`timescale 1ns/1ps

module mio_tb;

	localparam int                NMIO    = 8;
	localparam int                BEATS   = mio_pkg::PW / NMIO;
	localparam mio_pkg::mio_cfg_t DEF_CFG = '{enable: 1'b1, clkdiv: 4'd1};

	logic                   clk         = 1'b0;
	logic                   rst         = 1'b1;
	logic                   access_in   = 1'b0;
	mio_pkg::emesh_packet_t packet_in   = '0;
	logic                   wait_in     = 1'b0;
	logic                   reg_wait_in = 1'b0;
	logic                   wait_out;
	logic                   reg_wait_out;
	logic                   access_out;
	logic                   reg_access_out;
	logic                   tx_clk;
	mio_pkg::emesh_packet_t packet_out;
	mio_pkg::emesh_packet_t reg_packet_out;

	mio_pkg::emesh_packet_t exp_q[$];                // Link packets in flight
	mio_pkg::emesh_packet_t held_pkt;                // Output seen under wait_in
	logic                   held_valid = 1'b0;
	logic                   bp_on      = 1'b0;       // Random wait_in on
	int                     accepted   = 0;          // Link packets taken by DUT
	int                     received   = 0;
	logic [31:0]            lfsr       = 32'hd812_a5c8; // Stimulus fields
	logic [31:0]            wait_lfsr  = 32'hd812_a5c8; // Wait pattern

	always #50 clk = ~clk; // 100 ns period

	mio_loopback #(.NMIO(NMIO), .DEF_CFG(DEF_CFG)) dut0 (
		.clk            (clk),
		.rst            (rst),
		.access_in      (access_in),
		.packet_in      (packet_in),
		.wait_in        (wait_in),
		.reg_wait_in    (reg_wait_in),
		.wait_out       (wait_out),
		.reg_wait_out   (reg_wait_out),
		.access_out     (access_out),
		.reg_access_out (reg_access_out),
		.packet_out     (packet_out),
		.reg_packet_out (reg_packet_out),
		.tx_clk         (tx_clk)
	);

	//############################
	//# Random and failure helpers
	//############################
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1); // Galois step to the right
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]}; // One step per bit
		end
	endtask

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp) else
			fail_run($sformatf("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp));
	endtask

	//############################
	//# Packet stimulus
	//############################
	task automatic random_link_packet(output mio_pkg::emesh_packet_t p);
		logic [31:0] v;
		take_bits(8, v);
		p.ctrl = v[7:0];
		take_bits(32, v);
		p.dstaddr = v;
		if (p.dstaddr[31:20] == 12'd0) begin
			p.dstaddr[31] = 1'b1; // Keep it off the register space
		end
		take_bits(32, v);
		p.data = v;
		take_bits(32, v);
		p.srcaddr = v;
	endtask

	task automatic reg_packet(input mio_pkg::mio_reg_e idx, input logic wr,
		input logic [31:0] data, output mio_pkg::emesh_packet_t p);
		logic [31:0] v;
		take_bits(8, v);
		p.ctrl = {v[7:1], wr};
		take_bits(16, v);
		p.dstaddr = {12'd0, v[15:0], idx, 2'b00}; // Upper 12 bits zero
		p.data    = data;
		take_bits(32, v);
		p.srcaddr = v;
	endtask

	// Holds access and packet until the matching wait is low
	task automatic send_packet(input mio_pkg::emesh_packet_t p);
		logic reg_path;
		int   cycles;
		reg_path = (p.dstaddr[31:20] == 12'd0);
		cycles   = 0;
		@(posedge clk);
		access_in <= 1'b1;
		packet_in <= p;
		@(negedge clk);
		while (reg_path ? reg_wait_out : wait_out) begin
			cycles++;
			if (cycles > 2000) fail_run("Timeout: DUT never accepted a packet");
			@(negedge clk);
		end
		@(posedge clk); // Transfer edge
		access_in <= 1'b0;
		if (!reg_path) begin
			exp_q.push_back(p);
			accepted++;
		end
	endtask

	task automatic drain_link();
		int   cycles;
		logic empty;
		logic idle;
		cycles = 0;
		empty  = 1'b0;
		idle   = 1'b0;
		while (!(empty && idle)) begin
			cycles++;
			if (cycles > 5000) fail_run("Timeout: link packets did not come out");
			@(posedge clk);
			empty = (exp_q.size() == 0); // Queue only moves on negedge
			@(negedge clk);
			idle = !wait_out;
		end
	endtask

	task automatic write_reg(input mio_pkg::mio_reg_e idx, input logic [31:0] data);
		mio_pkg::emesh_packet_t p;
		reg_packet(idx, 1'b1, data, p);
		send_packet(p);
	endtask

	task automatic check_read(input mio_pkg::mio_reg_e idx, input logic [31:0] exp_data);
		mio_pkg::emesh_packet_t req;
		mio_pkg::emesh_packet_t resp;
		logic [31:0]            hold;
		reg_packet(idx, 1'b0, 32'd0, req);
		take_bits(2, hold); // Cycles of response back-pressure
		@(posedge clk);
		reg_wait_in <= (hold != 0);
		send_packet(req);
		@(negedge clk);
		check_value("reg_access_out", reg_access_out, 1'b1); // One cycle after accept
		check_value("reg_wait_out", reg_wait_out, 1'b1);
		resp = reg_packet_out;
		for (int i = 0; i < hold; i++) begin
			@(posedge clk);
			if (i == hold - 1) reg_wait_in <= 1'b0;
			@(negedge clk);
			check_value("reg_access_out", reg_access_out, 1'b1);
			check_value("reg_wait_out", reg_wait_out, 1'b1);
			check_value("reg_packet_out", reg_packet_out, resp);
		end
		@(posedge clk);
		@(negedge clk);
		check_value("reg_access_out", reg_access_out, 1'b0);
		check_value("reg_wait_out", reg_wait_out, 1'b0);
		check_value("reg_packet_out.ctrl[0]", resp.ctrl[0], 1'b1);
		check_value("reg_packet_out.dstaddr", resp.dstaddr, req.srcaddr); // Swapped
		check_value("reg_packet_out.srcaddr", resp.srcaddr, req.dstaddr);
		check_value("reg_packet_out.data", resp.data, exp_data);
	endtask

	// Every low and high phase of one packet lasts div+1 cycles
	task automatic check_phases(input logic [3:0] div);
		int   run;
		logic level;
		@(negedge clk);
		for (int ph = 0; ph < 2 * BEATS; ph++) begin
			level = ph[0]; // Low first
			run   = 0;
			while (tx_clk == level) begin
				run++;
				if (run > 40) fail_run("Timeout: tx_clk stuck in one phase");
				@(negedge clk);
			end
			check_value("tx_clk phase length", run, div + 1);
		end
	endtask

	//############################
	//# Link monitor and wait driver
	//############################
	always @(negedge clk) begin
		if (!rst) begin
			if (held_valid) begin
				assert (access_out) else fail_run("access_out dropped while wait_in was high");
				check_value("packet_out", packet_out, held_pkt);
			end
			held_valid = access_out && wait_in;
			held_pkt   = packet_out;
			if (access_out && !wait_in) begin
				assert (exp_q.size() != 0) else fail_run("Link packet came out with none sent");
				check_value("packet_out", packet_out, exp_q.pop_front());
				received++;
			end
		end
	end

	always @(posedge clk) begin
		wait_lfsr = lfsr_step(wait_lfsr);
		wait_in <= bp_on & wait_lfsr[0];
	end

	initial begin
		mio_pkg::emesh_packet_t p;
		logic [31:0]            v;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("access_out", access_out, 1'b0);
		check_value("reg_access_out", reg_access_out, 1'b0);
		check_value("tx_clk", tx_clk, 1'b0);
		check_value("wait_out", wait_out, !DEF_CFG.enable);
		for (int i = 0; i < 16; i++) begin
			random_link_packet(p);
			send_packet(p);
		end
		drain_link();
		@(posedge clk);
		bp_on <= 1'b1; // Random back-pressure on the link output
		for (int i = 0; i < 16; i++) begin
			random_link_packet(p);
			send_packet(p);
		end
		drain_link();
		@(posedge clk);
		bp_on <= 1'b0;
		take_bits(32, v);
		write_reg(mio_pkg::REG_SCRATCH, v);
		check_read(mio_pkg::REG_SCRATCH, v);
		check_read(mio_pkg::REG_STATUS, accepted);
		take_bits(32, v);
		write_reg(mio_pkg::REG_STATUS, v); // Dropped by the read-only status
		check_read(mio_pkg::REG_STATUS, accepted);
		check_read(mio_pkg::REG_CONFIG, {24'd0, DEF_CFG.clkdiv, 3'd0, DEF_CFG.enable});
		for (int r = 0; r < 2; r++) begin
			take_bits(4, v);
			write_reg(mio_pkg::REG_CONFIG, {24'd0, v[3:0], 4'b0001});
			random_link_packet(p);
			send_packet(p);
			check_phases(v[3:0]);
			drain_link();
		end
		write_reg(mio_pkg::REG_CONFIG, 32'h0000_0010); // Enable off
		@(negedge clk);
		check_value("wait_out", wait_out, 1'b1);
		random_link_packet(p);
		@(posedge clk);
		access_in <= 1'b1;
		packet_in <= p;
		repeat (4 * BEATS + 20) begin // Longer than one packet at divider 1
			@(negedge clk);
			check_value("wait_out", wait_out, 1'b1);
			check_value("access_out", access_out, 1'b0);
		end
		@(posedge clk);
		access_in <= 1'b0;
		@(posedge clk);
		if (exp_q.size() == 0 && received == accepted) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			fail_run("Link packets missing at the end of the run");
		end
	end

endmodule
